/* source/cnn_pkg.sv */
package cnn_pkg;

	// ------------------------------
	// Data widths
	// ------------------------------
	localparam int KERN_TAPS = 9;              // 3x3 window

	typedef logic        [7:0]  pix_t;         // Image pixel, unsigned
	typedef logic signed [7:0]  weight_t;      // Kernel weight
	typedef logic signed [15:0] coef_t;        // Scale or bias
	typedef logic signed [19:0] acc_t;         // Nine products summed
	typedef logic        [7:0]  act_t;         // Activation byte
	typedef logic        [11:0] dim_t;         // Frame width or height
	typedef logic        [11:0] delay_t;       // Delay in cycles
	typedef logic        [3:0]  reg_idx_t;     // Word index in register map

	// ------------------------------
	// Register map
	// ------------------------------
	localparam reg_idx_t REG_WIDTH_HEIGHT = 4'd1;
	localparam reg_idx_t REG_DELAY_PARAMS = 4'd2;
	localparam reg_idx_t REG_LAYER_CONFIG = 4'd4;
	localparam reg_idx_t REG_INPUT_IMAGE  = 4'd5;  // Table write, one pixel
	localparam reg_idx_t REG_WEIGHT       = 4'd6;  // Table write, one tap
	localparam reg_idx_t REG_PARAM        = 4'd7;  // Table write, scale and bias
	localparam reg_idx_t REG_LAYER_START  = 4'd8;
	localparam reg_idx_t REG_LAYER_DONE   = 4'd9;

	// AHB-Lite codes
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;
	localparam logic [1:0] HRESP_OKAY    = 2'b00;

	// Tap 0 top-left, tap 8 bottom-right
	typedef struct packed {
		pix_t [KERN_TAPS-1:0] tap;
	} win_t;

	typedef struct packed {
		dim_t   width;
		dim_t   height;
		delay_t start_up_delay;
		delay_t hsync_delay;
		logic   act_type;        // 0 ReLU, 1 linear
		logic [4:0] bias_shift;  // Applied before the bias add
		logic [2:0] act_shift;   // Applied after the bias add
		logic [1:0] rsvd;
	} layer_cfg_t;

	typedef struct packed {
		weight_t [KERN_TAPS-1:0] wt;
		coef_t scale;
		coef_t bias;
	} kern_coef_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_VSYNC,   // Start-up delay, coefficients load here
		ST_DATA,    // One pixel per cycle
		ST_HSYNC    // Gap between rows
	} frame_state_t;

endpackage

/* source/ahb_cfg_regs.sv */
`timescale 1ns/100ps

module ahb_cfg_regs #(
	parameter int IMG_AW       = 10,
	parameter int RST_WIDTH    = 16,
	parameter int RST_HEIGHT   = 16,
	parameter int RST_START_UP = 64,
	parameter int RST_HSYNC    = 8
) (
	input  logic clk,
	input  logic rstn,
	input  logic hsel_i,
	input  logic hready_i,
	input  logic [1:0] htrans_i,
	input  logic [31:0] haddr_i,
	input  logic hwrite_i,
	input  logic [31:0] hwdata_i,
	input  logic out_valid_i,
	output logic hready_o,
	output logic [1:0] hresp_o,
	output logic [31:0] hrdata_o,
	output cnn_pkg::layer_cfg_t cfg_o,
	output logic start_o,
	output logic img_we_o,
	output logic wt_we_o,
	output logic prm_we_o,
	output logic [IMG_AW-1:0] tbl_addr_o,
	output logic [31:0] tbl_data_o
);
	import cnn_pkg::*;

	reg_idx_t sel_q;              // Register of the pending data phase
	logic ld_q;                   // Pending write
	logic [IMG_AW-1:0] idx_q;     // Table index of the pending access
	logic [2*$bits(dim_t)-1:0] out_cnt;
	logic [2*$bits(dim_t)-1:0] frame_size;
	logic done_q;

	// ------------------------------
	// Address phase
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sel_q <= '0;
			ld_q  <= 1'b0;
			idx_q <= '0;
		end else if (hsel_i && hready_i &&
			(htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ)) begin
			sel_q <= haddr_i[5:2];
			ld_q  <= hwrite_i;
			idx_q <= haddr_i[6 +: IMG_AW];   // Word index above the register bits
		end else begin
			ld_q <= 1'b0;                    // IDLE or BUSY, sel_q kept for reads
		end
	end

	// ------------------------------
	// Data phase, register writes
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cfg_o <= '{
				width:          dim_t'(RST_WIDTH),
				height:         dim_t'(RST_HEIGHT),
				start_up_delay: delay_t'(RST_START_UP),
				hsync_delay:    delay_t'(RST_HSYNC),
				act_type:       1'b0,
				bias_shift:     5'd9,
				act_shift:      3'd7,
				rsvd:           2'b00
			};
			start_o <= 1'b0;
		end else begin
			start_o <= ld_q && (sel_q == REG_LAYER_START) && hwdata_i[0];  // Single pulse
			if (ld_q) begin
				case (sel_q)
					REG_WIDTH_HEIGHT: begin
						cfg_o.width  <= hwdata_i[11:0];
						cfg_o.height <= hwdata_i[27:16];
					end
					REG_DELAY_PARAMS: begin
						cfg_o.start_up_delay <= hwdata_i[11:0];
						cfg_o.hsync_delay    <= hwdata_i[23:12];
					end
					REG_LAYER_CONFIG: begin
						cfg_o.act_type   <= hwdata_i[3];
						cfg_o.bias_shift <= hwdata_i[12:8];
						cfg_o.act_shift  <= hwdata_i[15:13];
					end
					default: ;
				endcase
			end
		end
	end

	// Table writes go straight through in the data phase
	assign img_we_o   = ld_q && (sel_q == REG_INPUT_IMAGE);
	assign wt_we_o    = ld_q && (sel_q == REG_WEIGHT);
	assign prm_we_o   = ld_q && (sel_q == REG_PARAM);
	assign tbl_addr_o = idx_q;
	assign tbl_data_o = hwdata_i;

	// ------------------------------
	// Output count and done flag
	// ------------------------------
	assign frame_size = cfg_o.width * cfg_o.height;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			out_cnt <= '0;
			done_q  <= 1'b0;
		end else if (start_o) begin
			out_cnt <= '0;      // New frame
			done_q  <= 1'b0;
		end else if (out_valid_i) begin
			out_cnt <= out_cnt + 1'b1;
			if (out_cnt + 1'b1 == frame_size)
				done_q <= 1'b1;  // Last pixel left the kernels
		end
	end

	// Always ready, never an error
	assign hready_o = 1'b1;
	assign hresp_o  = HRESP_OKAY;

	// Read mux on the registered index
	always_comb begin
		case (sel_q)
			REG_WIDTH_HEIGHT: hrdata_o = {4'h0, cfg_o.height, 4'h0, cfg_o.width};
			REG_DELAY_PARAMS: hrdata_o = {8'h0, cfg_o.hsync_delay, cfg_o.start_up_delay};
			REG_LAYER_CONFIG: hrdata_o = {16'h0, cfg_o.act_shift, cfg_o.bias_shift,
				4'h0, cfg_o.act_type, 3'h0};
			REG_LAYER_DONE:   hrdata_o = {31'h0, done_q};
			default:          hrdata_o = '0;   // Tables and start are write only
		endcase
	end

endmodule

/* source/frame_ctrl.sv */
`timescale 1ns/100ps

module frame_ctrl #(
	parameter int IMG_AW = 10
) (
	input  logic clk,
	input  logic rstn,
	input  cnn_pkg::layer_cfg_t cfg_i,
	input  logic start_i,
	output logic vsync_run_o,
	output cnn_pkg::delay_t vsync_cnt_o,
	output logic data_run_o,
	output cnn_pkg::dim_t row_o,
	output cnn_pkg::dim_t col_o,
	output logic [IMG_AW-1:0] pix_addr_o
);
	import cnn_pkg::*;

	frame_state_t state;
	logic last_col;
	logic last_row;

	assign last_col = (col_o == cfg_i.width - 1'b1);
	assign last_row = (row_o == cfg_i.height - 1'b1);

	// vsync_cnt_o doubles as the hsync counter, cleared on every DATA entry
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= ST_IDLE;
			vsync_cnt_o <= '0;
			row_o       <= '0;
			col_o       <= '0;
			pix_addr_o  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						state       <= ST_VSYNC;
						vsync_cnt_o <= '0;
					end
				end
				ST_VSYNC: begin
					if (vsync_cnt_o == cfg_i.start_up_delay - 1'b1) begin
						state       <= ST_DATA;
						vsync_cnt_o <= '0;
						row_o       <= '0;
						col_o       <= '0;
						pix_addr_o  <= '0;
					end else begin
						vsync_cnt_o <= vsync_cnt_o + 1'b1;
					end
				end
				ST_DATA: begin
					pix_addr_o <= pix_addr_o + 1'b1;   // Raster order, no row jump
					if (last_col) begin
						col_o <= '0;
						row_o <= row_o + 1'b1;
						if (last_row)
							state <= ST_IDLE;            // No gap after last row
						else if (cfg_i.hsync_delay != '0)
							state <= ST_HSYNC;
					end else begin
						col_o <= col_o + 1'b1;
					end
				end
				ST_HSYNC: begin
					if (vsync_cnt_o == cfg_i.hsync_delay - 1'b1) begin
						state       <= ST_DATA;
						vsync_cnt_o <= '0;
					end else begin
						vsync_cnt_o <= vsync_cnt_o + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign vsync_run_o = (state == ST_VSYNC);
	assign data_run_o  = (state == ST_DATA);

endmodule

/* source/window_fetch.sv */
`timescale 1ns/100ps

module window_fetch #(
	parameter int IMG_AW = 10
) (
	input  logic clk,
	input  logic rstn,
	input  cnn_pkg::layer_cfg_t cfg_i,
	input  logic img_we_i,
	input  logic [IMG_AW-1:0] tbl_addr_i,
	input  logic [31:0] tbl_data_i,
	input  logic data_run_i,
	input  cnn_pkg::dim_t row_i,
	input  cnn_pkg::dim_t col_i,
	input  logic [IMG_AW-1:0] pix_addr_i,
	output cnn_pkg::win_t win_o,
	output logic win_vld_o
);
	import cnn_pkg::*;

	pix_t img_mem [2**IMG_AW];           // Input frame, raster order
	logic [IMG_AW-1:0] width_a;
	logic [IMG_AW-1:0] row_base [3];     // Centre column of rows above, at, below
	logic [2:0] pad_r;                   // Window row falls off the image
	logic [2:0] pad_c;                   // Window column falls off the image
	win_t win_d;

	always_ff @(posedge clk) begin
		if (img_we_i)
			img_mem[tbl_addr_i] <= pix_t'(tbl_data_i[7:0]);
	end

	assign width_a     = IMG_AW'(cfg_i.width);
	assign row_base[0] = pix_addr_i - width_a;
	assign row_base[1] = pix_addr_i;
	assign row_base[2] = pix_addr_i + width_a;

	// Border flags, centre row and column never pad
	assign pad_r = {row_i == cfg_i.height - 1'b1, 1'b0, row_i == '0};
	assign pad_c = {col_i == cfg_i.width - 1'b1, 1'b0, col_i == '0};

	// ------------------------------
	// Zero-padded 3x3 gather
	// ------------------------------
	always_comb begin
		win_d = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (!(pad_r[r] || pad_c[c]))
					win_d.tap[3*r+c] = img_mem[row_base[r] + IMG_AW'(c) - IMG_AW'(1)];
			end
		end
	end

	always_ff @(posedge clk) begin
		win_o <= win_d;
	end

	// Valid travels with the window
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			win_vld_o <= 1'b0;
		else
			win_vld_o <= data_run_i;
	end

endmodule

/* source/coef_loader.sv */
`timescale 1ns/100ps

module coef_loader #(
	parameter int N_KERN = 4,
	parameter int IMG_AW = 10
) (
	input  logic clk,
	input  logic rstn,
	input  logic wt_we_i,
	input  logic prm_we_i,
	input  logic [IMG_AW-1:0] tbl_addr_i,
	input  logic [31:0] tbl_data_i,
	input  logic vsync_run_i,
	input  cnn_pkg::delay_t vsync_cnt_i,
	output cnn_pkg::kern_coef_t [N_KERN-1:0] coef_o
);
	import cnn_pkg::*;

	localparam int N_WT   = KERN_TAPS * N_KERN;
	localparam int WT_AW  = $clog2(N_WT);
	localparam int PRM_AW = (N_KERN > 1) ? $clog2(N_KERN) : 1;

	weight_t wt_mem [N_WT];          // Entry k*9+t is tap t of kernel k
	logic [31:0] prm_mem [N_KERN];   // {bias, scale}
	logic wt_rd_en;
	logic [WT_AW-1:0] wt_rd_addr;
	logic prm_rd_en;
	logic [PRM_AW-1:0] prm_rd_addr;
	weight_t wt_dout;
	logic [31:0] prm_dout;
	logic wt_en_d;
	logic [WT_AW-1:0] wt_addr_d;
	logic prm_en_d;
	logic [PRM_AW-1:0] prm_addr_d;

	// ------------------------------
	// Stores, bus write and sync read
	// ------------------------------
	always_ff @(posedge clk) begin
		if (wt_we_i && tbl_addr_i < N_WT)
			wt_mem[tbl_addr_i[WT_AW-1:0]] <= weight_t'(tbl_data_i[7:0]);
		if (prm_we_i && tbl_addr_i < N_KERN)
			prm_mem[tbl_addr_i[PRM_AW-1:0]] <= tbl_data_i;
		if (wt_rd_en)
			wt_dout <= wt_mem[wt_rd_addr];
		if (prm_rd_en)
			prm_dout <= prm_mem[prm_rd_addr];
	end

	// Walk the stores in the first start-up cycles
	assign wt_rd_en    = vsync_run_i && (vsync_cnt_i < N_WT);
	assign wt_rd_addr  = vsync_cnt_i[WT_AW-1:0];
	assign prm_rd_en   = vsync_run_i && (vsync_cnt_i < N_KERN);
	assign prm_rd_addr = vsync_cnt_i[PRM_AW-1:0];

	// Line up enable and address with the read data
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wt_en_d  <= 1'b0;
			prm_en_d <= 1'b0;
		end else begin
			wt_en_d  <= wt_rd_en;
			prm_en_d <= prm_rd_en;
		end
	end

	always_ff @(posedge clk) begin
		wt_addr_d  <= wt_rd_addr;
		prm_addr_d <= prm_rd_addr;
	end

	// ------------------------------
	// Per-kernel coefficient registers
	// ------------------------------
	always_ff @(posedge clk) begin
		for (int k = 0; k < N_KERN; k++) begin
			for (int t = 0; t < KERN_TAPS; t++) begin
				if (wt_en_d && wt_addr_d == WT_AW'(k*KERN_TAPS + t))
					coef_o[k].wt[t] <= wt_dout;
			end
			if (prm_en_d && prm_addr_d == PRM_AW'(k)) begin
				coef_o[k].scale <= coef_t'(prm_dout[15:0]);
				coef_o[k].bias  <= coef_t'(prm_dout[31:16]);
			end
		end
	end

endmodule

/* source/conv_kern.sv */
`timescale 1ns/100ps

module conv_kern (
	input  logic clk,
	input  logic rstn,
	input  cnn_pkg::layer_cfg_t cfg_i,
	input  cnn_pkg::kern_coef_t coef_i,
	input  cnn_pkg::win_t win_i,
	input  logic vld_i,
	output cnn_pkg::act_t act_o,
	output logic vld_o
);
	import cnn_pkg::*;

	localparam int PROD_W = $bits(pix_t) + $bits(weight_t) + 1;   // Pixel gets a sign bit
	localparam int SCL_W  = $bits(acc_t) + $bits(coef_t);

	logic signed [PROD_W-1:0] prod_q [KERN_TAPS];
	acc_t sum_d;
	acc_t acc_q;
	logic signed [SCL_W-1:0] scaled;
	logic signed [SCL_W:0] biased;       // One bit of headroom for the bias add
	logic signed [SCL_W:0] shifted;
	act_t act_d;
	logic [1:0] vld_q;                   // Valid after stage 1 and stage 2

	// ------------------------------
	// Stage 1, nine products
	// ------------------------------
	always_ff @(posedge clk) begin
		for (int t = 0; t < KERN_TAPS; t++) begin
			prod_q[t] <= $signed({1'b0, win_i.tap[t]}) * $signed(coef_i.wt[t]);
		end
	end

	// Stage 2, adder tree
	always_comb begin
		sum_d = '0;
		for (int t = 0; t < KERN_TAPS; t++) begin
			sum_d = sum_d + prod_q[t];   // Fits 20 bits for 8x8 operands
		end
	end

	always_ff @(posedge clk) begin
		acc_q <= sum_d;
	end

	// ------------------------------
	// Stage 3, scale, bias, activation
	// ------------------------------
	always_comb begin
		scaled  = acc_q * $signed(coef_i.scale);
		biased  = (scaled >>> cfg_i.bias_shift) + $signed(coef_i.bias);
		shifted = biased >>> cfg_i.act_shift;
		if (cfg_i.act_type) begin
			// Linear, saturate to a signed byte
			if (shifted > 127)
				act_d = 8'h7f;
			else if (shifted < -128)
				act_d = 8'h80;
			else
				act_d = shifted[7:0];
		end else begin
			// ReLU, saturate to an unsigned byte
			if (shifted < 0)
				act_d = 8'h00;
			else if (shifted > 255)
				act_d = 8'hff;
			else
				act_d = shifted[7:0];
		end
	end

	always_ff @(posedge clk) begin
		act_o <= act_d;
	end

	// Valid alongside the three stages
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			vld_q <= '0;
			vld_o <= 1'b0;
		end else begin
			vld_q <= {vld_q[0], vld_i};
			vld_o <= vld_q[1];
		end
	end

endmodule

/* source/cnn_accel.sv */
`timescale 1ns/100ps

module cnn_accel #(
	parameter int N_KERN       = 4,
	parameter int IMG_AW       = 10,
	parameter int RST_WIDTH    = 16,
	parameter int RST_HEIGHT   = 16,
	parameter int RST_START_UP = 64,
	parameter int RST_HSYNC    = 8
) (
	input  logic clk,
	input  logic rstn,
	// AHB-Lite slave
	input  logic hsel_i,
	input  logic hready_i,
	input  logic [1:0] htrans_i,
	input  logic [31:0] haddr_i,
	input  logic hwrite_i,
	input  logic [31:0] hwdata_i,
	output logic hready_o,
	output logic [1:0] hresp_o,
	output logic [31:0] hrdata_o,
	// Activation stream, byte k from kernel k
	output cnn_pkg::act_t [N_KERN-1:0] out_pixel_o,
	output logic out_valid_o
);
	import cnn_pkg::*;

	layer_cfg_t cfg;
	logic start;
	logic img_we;
	logic wt_we;
	logic prm_we;
	logic [IMG_AW-1:0] tbl_addr;
	logic [31:0] tbl_data;
	logic vsync_run;
	delay_t vsync_cnt;
	logic data_run;
	dim_t row;
	dim_t col;
	logic [IMG_AW-1:0] pix_addr;
	win_t win;
	logic win_vld;
	kern_coef_t [N_KERN-1:0] coef;
	logic [N_KERN-1:0] kern_vld;

	ahb_cfg_regs #(
		.IMG_AW      (IMG_AW),
		.RST_WIDTH   (RST_WIDTH),
		.RST_HEIGHT  (RST_HEIGHT),
		.RST_START_UP(RST_START_UP),
		.RST_HSYNC   (RST_HSYNC)
	) u_regs (
		.clk        (clk),
		.rstn       (rstn),
		.hsel_i     (hsel_i),
		.hready_i   (hready_i),
		.htrans_i   (htrans_i),
		.haddr_i    (haddr_i),
		.hwrite_i   (hwrite_i),
		.hwdata_i   (hwdata_i),
		.out_valid_i(out_valid_o),
		.hready_o   (hready_o),
		.hresp_o    (hresp_o),
		.hrdata_o   (hrdata_o),
		.cfg_o      (cfg),
		.start_o    (start),
		.img_we_o   (img_we),
		.wt_we_o    (wt_we),
		.prm_we_o   (prm_we),
		.tbl_addr_o (tbl_addr),
		.tbl_data_o (tbl_data)
	);

	frame_ctrl #(.IMG_AW(IMG_AW)) u_ctrl (
		.clk        (clk),
		.rstn       (rstn),
		.cfg_i      (cfg),
		.start_i    (start),
		.vsync_run_o(vsync_run),
		.vsync_cnt_o(vsync_cnt),
		.data_run_o (data_run),
		.row_o      (row),
		.col_o      (col),
		.pix_addr_o (pix_addr)
	);

	window_fetch #(.IMG_AW(IMG_AW)) u_win (
		.clk       (clk),
		.rstn      (rstn),
		.cfg_i     (cfg),
		.img_we_i  (img_we),
		.tbl_addr_i(tbl_addr),
		.tbl_data_i(tbl_data),
		.data_run_i(data_run),
		.row_i     (row),
		.col_i     (col),
		.pix_addr_i(pix_addr),
		.win_o     (win),
		.win_vld_o (win_vld)
	);

	coef_loader #(.N_KERN(N_KERN), .IMG_AW(IMG_AW)) u_coef (
		.clk        (clk),
		.rstn       (rstn),
		.wt_we_i    (wt_we),
		.prm_we_i   (prm_we),
		.tbl_addr_i (tbl_addr),
		.tbl_data_i (tbl_data),
		.vsync_run_i(vsync_run),
		.vsync_cnt_i(vsync_cnt),
		.coef_o     (coef)
	);

	// ------------------------------
	// Kernel array
	// ------------------------------
	for (genvar k = 0; k < N_KERN; k++) begin : g_kern
		conv_kern u_kern (
			.clk   (clk),
			.rstn  (rstn),
			.cfg_i (cfg),
			.coef_i(coef[k]),
			.win_i (win),
			.vld_i (win_vld),
			.act_o (out_pixel_o[k]),
			.vld_o (kern_vld[k])
		);
	end

	assign out_valid_o = kern_vld[0];   // All kernels run in lockstep

endmodule

/* verif/cnn_checker.sv */
`timescale 1ns/100ps

module cnn_checker #(
	parameter int N_KERN = 4,
	parameter int IMG_AW = 10
) (
	input  logic clk,
	input  logic rstn,
	input  cnn_pkg::act_t [N_KERN-1:0] out_pixel_i,
	input  logic out_valid_i,
	input  logic hready_i,
	input  logic [1:0] hresp_i
);
	import cnn_pkg::*;

	int img [2**IMG_AW];            // Copy of the image as written
	int wt [N_KERN*KERN_TAPS];      // Signed taps, kernel major
	int scale [N_KERN];
	int bias [N_KERN];
	int width = 0;
	int height = 0;
	int hsync = 0;
	int act_lin = 0;                // 1 for linear
	int b_shift = 0;
	int a_shift = 0;
	int exp_idx = 0;                // Next raster pixel expected
	int burst_len = 0;
	int gap_len = 0;
	int exp_val;
	int errors = 0;
	int checks = 0;

	// ------------------------------
	// Mirror of the bus table writes
	// ------------------------------
	task automatic set_pixel(input int idx, input int val);
		img[idx] = val;
	endtask

	task automatic set_weight(input int idx, input int val);
		wt[idx] = val;
	endtask

	task automatic set_param(input int k, input int s, input int b);
		scale[k] = s;
		bias[k]  = b;
	endtask

	task automatic start_frame(input int w, input int h, input int lin, input int bs,
		input int ash, input int hs);
		width     = w;
		height    = h;
		act_lin   = lin;
		b_shift   = bs;
		a_shift   = ash;
		hsync     = hs;
		exp_idx   = 0;
		burst_len = 0;
		gap_len   = 0;
	endtask

	task automatic finish_frame();
		if (exp_idx != width * height) begin
			$display("Frame gave %0d output pixels where %0d were expected", exp_idx,
				width * height);
			errors++;
		end
	endtask

	// Reference activation of kernel k at raster index idx
	function automatic int expect_act(input int idx, input int k);
		int r;
		int c;
		int rr;
		int cc;
		int p;
		longint sum;
		longint v;
		r   = idx / width;
		c   = idx % width;
		sum = 0;
		for (int dr = 0; dr < 3; dr++) begin
			for (int dc = 0; dc < 3; dc++) begin
				rr = r + dr - 1;
				cc = c + dc - 1;
				if (rr < 0 || rr >= height || cc < 0 || cc >= width)
					p = 0;                           // Zero padding
				else
					p = img[rr*width + cc];
				sum += p * wt[k*KERN_TAPS + 3*dr + dc];
			end
		end
		v = ((sum * scale[k]) >>> b_shift) + bias[k];
		v = v >>> a_shift;
		if (act_lin != 0) begin
			if (v > 127) v = 127;                  // Signed byte range
			if (v < -128) v = -128;
		end else begin
			if (v < 0) v = 0;                      // ReLU
			if (v > 255) v = 255;
		end
		return int'(v) & 255;
	endfunction

	// ------------------------------
	// Output watch, sampled mid-cycle
	// ------------------------------
	always @(negedge clk) begin
		if (rstn) begin
			if (hready_i !== 1'b1 || hresp_i !== 2'b00) begin
				$display("Bus not ready or response not OKAY at %0t", $time);
				errors++;
			end
			if (out_valid_i) begin
				if (exp_idx >= width * height) begin
					$display("Output strobe past the end of the frame at %0t", $time);
					errors++;
				end else begin
					if (burst_len == 0 && exp_idx > 0 && gap_len < hsync) begin
						$display("Row gap of %0d cycles is shorter than %0d at %0t",
							gap_len, hsync, $time);
						errors++;
					end
					for (int k = 0; k < N_KERN; k++) begin
						exp_val = expect_act(exp_idx, k);
						checks++;
						if (out_pixel_i[k] !== act_t'(exp_val)) begin
							$display("MISMATCH %0t: pixel %0d kernel %0d got %02h expected %02h",
								$time, exp_idx, k, out_pixel_i[k], exp_val);
							errors++;
						end
					end
					exp_idx++;
					burst_len++;
					if (burst_len > width) begin
						$display("Strobe burst longer than the row at %0t", $time);
						errors++;
					end
				end
				gap_len = 0;
			end else begin
				if (burst_len != 0 && burst_len != width) begin
					$display("Strobe burst of %0d, row width %0d, at %0t", burst_len, width,
						$time);
					errors++;
				end
				burst_len = 0;
				gap_len++;
			end
		end
	end

endmodule

/* verif/tb_cnn_accel.sv */
`timescale 1ns/100ps

module tb_cnn_accel;
	import cnn_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int N_KERN     = 4;
	localparam int IMG_AW     = 10;
	localparam int RST_W      = 16;
	localparam int RST_H      = 16;
	localparam int RST_SU     = 64;
	localparam int RST_HS     = 8;

	// Frame width, height, start-up delay and row gap
	localparam int F1_W  = 8;
	localparam int F1_H  = 6;
	localparam int F1_SU = 48;
	localparam int F1_HS = 3;
	localparam int F2_SU = 40;
	localparam int F2_HS = 5;
	localparam int F3_W  = 11;
	localparam int F3_H  = 5;
	localparam int F3_SU = 60;
	localparam int F3_HS = 2;

	// Bus loading at two cycles per write plus the frame itself
	function automatic int frame_budget(input int w, input int h, input int su, input int hs);
		return 2 * (w*h + 10*N_KERN + 8) + su + w*h + (h-1)*hs + 40;
	endfunction

	localparam int BUDGET = 200 + frame_budget(F1_W, F1_H, F1_SU, F1_HS)
		+ frame_budget(F1_W, F1_H, F2_SU, F2_HS) + frame_budget(F3_W, F3_H, F3_SU, F3_HS);
	localparam int WATCHDOG_NS = 2 * BUDGET * CLK_PERIOD;

	logic clk;
	logic rstn;
	logic hsel_i;
	logic hready_i;
	logic [1:0] htrans_i;
	logic [31:0] haddr_i;
	logic hwrite_i;
	logic [31:0] hwdata_i;
	logic hready_o;
	logic [1:0] hresp_o;
	logic [31:0] hrdata_o;
	act_t [N_KERN-1:0] out_pixel_o;
	logic out_valid_o;
	logic [31:0] rng;
	int tb_errs = 0;        // Register and done flag failures
	int n_tests = 0;
	int n_failed = 0;

	cnn_accel #(
		.N_KERN      (N_KERN),
		.IMG_AW      (IMG_AW),
		.RST_WIDTH   (RST_W),
		.RST_HEIGHT  (RST_H),
		.RST_START_UP(RST_SU),
		.RST_HSYNC   (RST_HS)
	) i_cnn_accel (
		.clk        (clk),
		.rstn       (rstn),
		.hsel_i     (hsel_i),
		.hready_i   (hready_i),
		.htrans_i   (htrans_i),
		.haddr_i    (haddr_i),
		.hwrite_i   (hwrite_i),
		.hwdata_i   (hwdata_i),
		.hready_o   (hready_o),
		.hresp_o    (hresp_o),
		.hrdata_o   (hrdata_o),
		.out_pixel_o(out_pixel_o),
		.out_valid_o(out_valid_o)
	);

	cnn_checker #(.N_KERN(N_KERN), .IMG_AW(IMG_AW)) u_chk (
		.clk        (clk),
		.rstn       (rstn),
		.out_pixel_i(out_pixel_o),
		.out_valid_i(out_valid_o),
		.hready_i   (hready_o),
		.hresp_i    (hresp_o)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// xorshift32 step on the state in rng
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	function automatic int total_errors();
		return tb_errs + u_chk.errors;
	endfunction

	// ------------------------------
	// AHB-Lite transfers
	// ------------------------------
	task automatic write_reg(input reg_idx_t sel, input int idx, input logic [31:0] data);
		@(posedge clk);
		hsel_i   <= 1'b1;
		htrans_i <= HTRANS_NONSEQ;
		haddr_i  <= {idx[25:0], sel, 2'b00};     // Table index above the register bits
		hwrite_i <= 1'b1;
		@(posedge clk);
		htrans_i <= 2'b00;                       // Data phase
		hwrite_i <= 1'b0;
		hwdata_i <= data;
	endtask

	task automatic read_reg(input reg_idx_t sel, output logic [31:0] data);
		@(posedge clk);
		hsel_i   <= 1'b1;
		htrans_i <= HTRANS_NONSEQ;
		haddr_i  <= {26'd0, sel, 2'b00};
		hwrite_i <= 1'b0;
		@(posedge clk);
		htrans_i <= 2'b00;
		@(negedge clk);
		data = hrdata_o;                         // Settled mid data phase
	endtask

	task automatic check_reg(input reg_idx_t sel, input logic [31:0] exp);
		logic [31:0] got;
		read_reg(sel, got);
		if (got !== exp) begin
			$display("MISMATCH %0t: register %0d reads %08h expected %08h", $time, sel, got, exp);
			tb_errs++;
		end
	endtask

	task automatic report_test(input string name, input int base);
		n_tests++;
		if (total_errors() == base) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: fail with %0d errors", name, total_errors() - base);
			n_failed++;
		end
	endtask

	// Reset values then random readback
	task automatic register_test();
		logic [31:0] v;
		check_reg(REG_WIDTH_HEIGHT, (RST_H << 16) | RST_W);
		check_reg(REG_DELAY_PARAMS, (RST_HS << 12) | RST_SU);
		check_reg(REG_LAYER_CONFIG, (7 << 13) | (9 << 8));
		repeat (4) begin
			v = next_rand();
			write_reg(REG_WIDTH_HEIGHT, 0, v);
			check_reg(REG_WIDTH_HEIGHT, v & 32'h0fff0fff);
			v = next_rand();
			write_reg(REG_DELAY_PARAMS, 0, v);
			check_reg(REG_DELAY_PARAMS, v & 32'h00ffffff);
			v = next_rand();
			write_reg(REG_LAYER_CONFIG, 0, v);
			check_reg(REG_LAYER_CONFIG, v & 32'h0000ff08);   // act_type and both shifts
		end
	endtask

	// ------------------------------
	// One frame from load to done
	// ------------------------------
	task automatic run_frame(input int w, input int h, input int su, input int hs,
		input int lin, input int bs, input int ash);
		logic [31:0] r;
		logic [31:0] done;
		int wv;
		int sv;
		int bv;
		int polls;
		write_reg(REG_WIDTH_HEIGHT, 0, (h << 16) | w);
		write_reg(REG_DELAY_PARAMS, 0, (hs << 12) | su);
		write_reg(REG_LAYER_CONFIG, 0, (ash << 13) | (bs << 8) | (lin << 3));
		for (int i = 0; i < w*h; i++) begin
			r = next_rand();
			write_reg(REG_INPUT_IMAGE, i, {24'd0, r[7:0]});
			u_chk.set_pixel(i, r[7:0]);
		end
		for (int i = 0; i < N_KERN*KERN_TAPS; i++) begin
			r  = next_rand();
			wv = $signed(r[3:0]);                  // -8..7
			write_reg(REG_WEIGHT, i, {24'd0, {4{r[3]}}, r[3:0]});
			u_chk.set_weight(i, wv);
		end
		for (int k = 0; k < N_KERN; k++) begin
			r  = next_rand();
			sv = r[5:0];                           // 0..63
			bv = $signed(r[12:6]);                 // -64..63
			write_reg(REG_PARAM, k, {bv[15:0], sv[15:0]});
			u_chk.set_param(k, sv, bv);
		end
		u_chk.start_frame(w, h, lin, bs, ash, hs);
		write_reg(REG_LAYER_START, 0, 32'd1);
		read_reg(REG_LAYER_DONE, done);
		if (done !== 32'd0) begin
			$display("MISMATCH %0t: LAYER_DONE reads %0d just after start", $time, done);
			tb_errs++;
		end
		polls = 0;
		while (done !== 32'd1 && polls < su + w*h + h*hs + 50) begin
			read_reg(REG_LAYER_DONE, done);
			polls++;
		end
		if (done !== 32'd1) begin
			$display("LAYER_DONE never went high, the frame did not complete");
			tb_errs++;
		end else if (out_valid_o === 1'b1 || u_chk.exp_idx != w*h) begin
			$display("LAYER_DONE went high before the last output pixel at %0t", $time);
			tb_errs++;
		end
		repeat (8) @(posedge clk);                 // Catch stray strobes
		u_chk.finish_frame();
	endtask

	initial begin
		int base;
		clk      = 1'b0;
		rstn     = 1'b0;
		hsel_i   = 1'b0;
		hready_i = 1'b1;
		htrans_i = 2'b00;
		haddr_i  = '0;
		hwrite_i = 1'b0;
		hwdata_i = '0;
		rng      = 32'h404c;
		repeat (10) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		base = total_errors();
		register_test();
		report_test("register access", base);
		base = total_errors();
		run_frame(F1_W, F1_H, F1_SU, F1_HS, 0, 6, 2);
		report_test("relu frame 8x6", base);
		base = total_errors();
		run_frame(F1_W, F1_H, F2_SU, F2_HS, 1, 9, 3);
		report_test("linear frame 8x6", base);
		base = total_errors();
		run_frame(F3_W, F3_H, F3_SU, F3_HS, 0, 7, 1);
		report_test("restart with frame 11x5", base);
		$display("Tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed,
			u_chk.checks, total_errors());
		if (total_errors() == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* cnn_accel.f */
source/cnn_pkg.sv
source/ahb_cfg_regs.sv
source/frame_ctrl.sv
source/window_fetch.sv
source/coef_loader.sv
source/conv_kern.sv
source/cnn_accel.sv
verif/cnn_checker.sv
verif/tb_cnn_accel.sv
